// ==== compile.f ====
lsuPkg.sv
wbBus.sv
busArbiter.sv
loadStoreUnit.sv
wordMemory.sv
ioManager.sv
memSubsystem.sv
memSubsystem_sva.sv
tbMemSubsystem.sv

// ==== runSim.sh ====
#!/bin/sh
set -e

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbMemSubsystem -f compile.f -o simMemSubsystem

./obj_dir/simMemSubsystem | tee sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1

// ==== tbMemSubsystem.sv ====
`timescale 1ns/100ps

module tbMemSubsystem;
    logic        clk;
    logic        rstN;
    logic        port0Req;
    logic [3:0]  port0Op;
    logic [15:0] port0Addr;
    logic [15:0] port0Store;
    logic [3:0]  port0Dest;
    logic        port0Ack;
    logic [15:0] port0Load;
    logic [3:0]  port0LoadDest;
    logic        port0Fault;
    logic        port1Req;
    logic [3:0]  port1Op;
    logic [15:0] port1Addr;
    logic [15:0] port1Store;
    logic [3:0]  port1Dest;
    logic        port1Ack;
    logic [15:0] port1Load;
    logic [3:0]  port1LoadDest;
    logic        port1Fault;

    // Stimulus table where port 2 means both ports at once
    int          entryCount;
    int          ePort [64];
    logic [3:0]  eOp [64];
    logic [15:0] eAddr [64];
    logic [15:0] eData [64];
    logic [3:0]  eDest [64];

    // Reference model
    logic [7:0]  fixedMem [1024];
    logic [7:0]  ramMem [1024];
    logic [7:0]  ioMem [16];
    logic [15:0] ioCount;

    logic [15:0] lfsrState;
    int          cycleCount;
    int          cycleLimit;
    int          errorCount;
    int          checkCount;
    logic        lastServed;

    memSubsystem i_memSubsystem (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: an ack never arrived within %0d cycles", cycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [15:0] randomBits(int n);
        logic [15:0] result;
        result = '0;
        for (int i = 0; i < n; i++) begin
            result = {result[14:0], lfsrState[0]};
            if (lfsrState[0])
                lfsrState = (lfsrState >> 1) ^ 16'hB400;  // Galois taps
            else
                lfsrState = lfsrState >> 1;
        end
        return result;
    endfunction

    function automatic logic [3:0] opcode(logic store, logic signedLoad, logic [1:0] size);
        logic [3:0] op;
        op = {2'b00, size};
        op[lsuPkg::opStoreBit]  = store;
        op[lsuPkg::opSignedBit] = signedLoad;
        return op;
    endfunction

    function automatic int regionOf(logic [15:0] addr);
        if (addr >= 16'd1024)
            return 2;
        if (addr >= 16'd384 && addr <= 16'd511)
            return 1;
        return 0;
    endfunction

    function automatic logic [7:0] readByte(logic [15:0] addr);
        case (regionOf(addr))
            0: return fixedMem[addr[9:0]];
            2: return ramMem[addr[9:0]];
            default: begin
                if (addr[3:1] == 3'd7)
                    return addr[0] ? ioCount[15:8] : ioCount[7:0];
                return ioMem[addr[3:0]];
            end
        endcase
    endfunction

    task automatic writeByte(logic [15:0] addr, logic [7:0] value);
        case (regionOf(addr))
            0: fixedMem[addr[9:0]] = value;
            2: ramMem[addr[9:0]] = value;
            default: if (addr[3:1] != 3'd7) ioMem[addr[3:0]] = value;  // Counter is read-only
        endcase
    endtask

    task automatic addEntry(int port, logic [3:0] op, logic [15:0] addr,
                            logic [15:0] data, logic [3:0] dest);
        ePort[entryCount] = port;
        eOp[entryCount]   = op;
        eAddr[entryCount] = addr;
        eData[entryCount] = data;
        eDest[entryCount] = dest;
        entryCount++;
    endtask

    task automatic checkValue(string name, logic [15:0] got, logic [15:0] expected);
        checkCount++;
        assert (got === expected) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, got);
            errorCount++;
        end
    endtask

    task automatic driveEntry(int p, logic req, logic [3:0] op, logic [15:0] addr,
                              logic [15:0] data, logic [3:0] dest);
        if (p == 0) begin
            port0Req = req;
            port0Op = op;
            port0Addr = addr;
            port0Store = data;
            port0Dest = dest;
        end else begin
            port1Req = req;
            port1Op = op;
            port1Addr = addr;
            port1Store = data;
            port1Dest = dest;
        end
    endtask

    task automatic processAck(int p, logic [3:0] op, logic [15:0] addr, logic [15:0] data,
                              logic [3:0] dest, int latency, logic contended);
        logic [15:0] gotLoad;
        logic [15:0] expLoad;
        logic [7:0]  b;
        logic        expFault;
        int          expLatency;
        gotLoad  = p ? port1Load : port0Load;
        expFault = op[1];
        expLatency = (!expFault && regionOf(addr) == 2) ? 4 : 2;
        checkValue(p ? "port1Fault" : "port0Fault", p ? port1Fault : port0Fault, expFault);
        checkValue(p ? "port1LoadDest" : "port0LoadDest",
                   p ? port1LoadDest : port0LoadDest, dest);
        if (!contended)
            checkValue("latency", latency, expLatency);
        if (expFault) begin
            checkValue(p ? "port1Load" : "port0Load", gotLoad, 16'h0000);
        end else if (op[lsuPkg::opStoreBit]) begin
            if (regionOf(addr) == 1)
                ioCount++;
            if (op[1:0] == 2'b01) begin
                writeByte({addr[15:1], 1'b0}, data[7:0]);
                writeByte({addr[15:1], 1'b1}, data[15:8]);
            end else begin
                writeByte(addr, data[7:0]);
            end
        end else begin
            if (op[1:0] == 2'b01) begin
                expLoad = {readByte({addr[15:1], 1'b1}), readByte({addr[15:1], 1'b0})};
            end else begin
                b = readByte(addr);
                expLoad = {(op[lsuPkg::opSignedBit] ? {8{b[7]}} : 8'h00), b};
            end
            checkValue(p ? "port1Load" : "port0Load", gotLoad, expLoad);
        end
    endtask

    task automatic runEntry(int k);
        int   start;
        logic pend0;
        logic pend1;
        logic contended;
        logic firstDone;
        logic [15:0] addr1;
        logic [15:0] data1;
        logic [3:0]  dest1;
        contended = (ePort[k] == 2);
        pend0 = (ePort[k] != 1);
        pend1 = (ePort[k] != 0);
        firstDone = 1'b0;
        // Second port of a contended pair uses neighbouring fields
        addr1 = contended ? eAddr[k] + 16'd2 : eAddr[k];
        data1 = contended ? ~eData[k] : eData[k];
        dest1 = contended ? eDest[k] + 4'd1 : eDest[k];
        if (pend0)
            driveEntry(0, 1'b1, eOp[k], eAddr[k], eData[k], eDest[k]);
        if (pend1)
            driveEntry(1, 1'b1, eOp[k], addr1, data1, dest1);
        start = cycleCount;
        while (pend0 || pend1) begin
            @(negedge clk);
            assert (!((port0Ack && !pend0) || (port1Ack && !pend1))) else begin
                $display("Entry %0d: ack arrived on a port with no request", k);
                errorCount++;
            end
            if (port0Ack && pend0) begin
                if (contended && !firstDone)
                    checkValue("first grant", 16'(0), {15'd0, ~lastServed});
                processAck(0, eOp[k], eAddr[k], eData[k], eDest[k],
                           cycleCount - start, contended);
                pend0 = 1'b0;
                firstDone = 1'b1;
                lastServed = 1'b0;
            end
            if (port1Ack && pend1) begin
                if (contended && !firstDone)
                    checkValue("first grant", 16'(1), {15'd0, ~lastServed});
                processAck(1, eOp[k], addr1, data1, dest1, cycleCount - start, contended);
                pend1 = 1'b0;
                firstDone = 1'b1;
                lastServed = 1'b1;
            end
            @(posedge clk);
            #2;
            if (!pend0)
                port0Req = 1'b0;
            if (!pend1)
                port1Req = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        driveEntry(0, 1'b0, '0, '0, '0, '0);
        driveEntry(1, 1'b0, '0, '0, '0, '0);
        lfsrState = 16'd51573;
        cycleCount = 0;
        cycleLimit = 0;
        errorCount = 0;
        checkCount = 0;
        entryCount = 0;
        lastServed = 1'b1;  // Port 0 takes the first tie
        ioCount = '0;
        for (int i = 0; i < 16; i++)
            ioMem[i] = 8'h00;

        // Region bounds and aliasing
        addEntry(0, opcode(1, 0, 2'b01), 16'd0, 16'h1234, 4'd1);
        addEntry(0, opcode(0, 0, 2'b01), 16'd0, 16'h0000, 4'd2);
        addEntry(1, opcode(1, 0, 2'b01), 16'd382, 16'hA5C3, 4'd3);
        addEntry(1, opcode(0, 0, 2'b01), 16'd382, 16'h0000, 4'd4);
        addEntry(0, opcode(1, 0, 2'b01), 16'd384, 16'hBEEF, 4'd5);
        addEntry(0, opcode(0, 0, 2'b01), 16'd384, 16'h0000, 4'd6);
        addEntry(0, opcode(1, 0, 2'b01), 16'd510, 16'hFFFF, 4'd7);
        addEntry(1, opcode(0, 0, 2'b01), 16'd510, 16'h0000, 4'd8);
        addEntry(0, opcode(1, 0, 2'b01), 16'd512, 16'h0F0F, 4'd9);
        addEntry(0, opcode(0, 0, 2'b01), 16'd512, 16'h0000, 4'd10);
        addEntry(1, opcode(1, 0, 2'b01), 16'd1022, 16'h7E81, 4'd11);
        addEntry(1, opcode(0, 0, 2'b01), 16'd1022, 16'h0000, 4'd12);
        addEntry(0, opcode(1, 0, 2'b01), 16'd1024, 16'hC0DE, 4'd13);
        addEntry(0, opcode(0, 0, 2'b01), 16'd1024, 16'h0000, 4'd14);
        addEntry(1, opcode(1, 0, 2'b01), 16'd3000, 16'h4321, 4'd15);
        addEntry(0, opcode(0, 0, 2'b01), 16'd1976, 16'h0000, 4'd0);

        // Byte lanes and extension
        addEntry(0, opcode(1, 0, 2'b01), 16'd4, 16'h1122, 4'd1);
        addEntry(0, opcode(1, 0, 2'b00), 16'd5, 16'h00F0, 4'd2);
        addEntry(0, opcode(0, 0, 2'b01), 16'd4, 16'h0000, 4'd3);
        addEntry(1, opcode(0, 1, 2'b00), 16'd5, 16'h0000, 4'd4);
        addEntry(1, opcode(0, 0, 2'b00), 16'd5, 16'h0000, 4'd5);
        addEntry(0, opcode(1, 0, 2'b00), 16'd4, 16'h0083, 4'd6);
        addEntry(0, opcode(0, 1, 2'b00), 16'd4, 16'h0000, 4'd7);
        addEntry(0, opcode(0, 0, 2'b01), 16'd4, 16'h0000, 4'd8);
        addEntry(1, opcode(1, 0, 2'b01), 16'd1030, 16'h5566, 4'd9);
        addEntry(1, opcode(1, 0, 2'b00), 16'd1031, 16'h0099, 4'd10);
        addEntry(0, opcode(0, 1, 2'b00), 16'd1031, 16'h0000, 4'd11);

        // IO aliasing and write counter
        addEntry(0, opcode(1, 0, 2'b01), 16'd386, 16'h2468, 4'd12);
        addEntry(1, opcode(0, 0, 2'b01), 16'd402, 16'h0000, 4'd13);
        addEntry(0, opcode(1, 0, 2'b00), 16'd399, 16'h0055, 4'd14);
        addEntry(0, opcode(0, 0, 2'b01), 16'd414, 16'h0000, 4'd15);

        // Unsupported sizes
        addEntry(0, opcode(0, 0, 2'b10), 16'd0, 16'h0000, 4'd1);
        addEntry(1, opcode(1, 0, 2'b11), 16'd0, 16'hDEAD, 4'd2);
        addEntry(0, opcode(0, 0, 2'b01), 16'd0, 16'h0000, 4'd3);

        // Contention and grant alternation
        addEntry(2, opcode(1, 0, 2'b01), 16'd100, randomBits(16), 4'd4);
        addEntry(2, opcode(0, 0, 2'b01), 16'd100, 16'h0000, 4'd6);
        addEntry(1, opcode(0, 0, 2'b01), 16'd100, 16'h0000, 4'd8);
        addEntry(2, opcode(1, 0, 2'b01), 16'd1100, randomBits(16), 4'd9);
        addEntry(2, opcode(0, 0, 2'b01), 16'd1100, 16'h0000, 4'd11);

        // Filler
        addEntry(1, opcode(1, 0, 2'b01), 16'd200, randomBits(16), 4'd13);
        addEntry(0, opcode(0, 0, 2'b01), 16'd200, 16'h0000, 4'd14);
        addEntry(1, opcode(1, 0, 2'b01), 16'd2048, randomBits(16), 4'd15);
        addEntry(1, opcode(0, 1, 2'b00), 16'd2049, 16'h0000, 4'd0);

        cycleLimit = entryCount * 12 + 3;

        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;
        @(posedge clk);
        #2;
        for (int k = 0; k < entryCount; k++)
            runEntry(k);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    bind memSubsystem memSubsystem_sva i_memSubsystemSva (
        .clk      (clk),
        .rstN     (rstN),
        .armStb   (armBus.stb),
        .armAck   (armBus.ack),
        .fixedStb (fixedBus.stb),
        .fixedAck (fixedBus.ack),
        .ioStb    (ioBus.stb),
        .ioAck    (ioBus.ack),
        .ramStb   (ramBus.stb),
        .ramAck   (ramBus.ack)
    );

endmodule

// ==== memSubsystem_sva.sv ====
`timescale 1ns/100ps

module memSubsystem_sva (
    input logic clk,
    input logic rstN,
    input logic armStb,
    input logic armAck,
    input logic fixedStb,
    input logic fixedAck,
    input logic ioStb,
    input logic ioAck,
    input logic ramStb,
    input logic ramAck
);
    // One-cycle acks on every bus
    armAckPulse: assert property (@(posedge clk) disable iff (!rstN) armAck |=> !armAck)
        else $error("armBus ack high two cycles in a row");
    fixedAckPulse: assert property (@(posedge clk) disable iff (!rstN) fixedAck |=> !fixedAck)
        else $error("fixedBus ack high two cycles in a row");
    ioAckPulse: assert property (@(posedge clk) disable iff (!rstN) ioAck |=> !ioAck)
        else $error("ioBus ack high two cycles in a row");
    ramAckPulse: assert property (@(posedge clk) disable iff (!rstN) ramAck |=> !ramAck)
        else $error("ramBus ack high two cycles in a row");

    armStbHold: assert property (@(posedge clk) disable iff (!rstN) armStb && !armAck |=> armStb)
        else $error("armBus stb dropped before ack");

    // armBus goes idle for one cycle after each ack
    slaveIdleAfterAck: assert property (@(posedge clk) disable iff (!rstN)
        armAck |=> !(fixedStb || ioStb || ramStb))
        else $error("Slave stb while armBus idle");

endmodule

// ==== memSubsystem.sv ====
`timescale 1ns/100ps

module memSubsystem (
    input  logic                            clk,
    input  logic                            rstN,

    input  logic                            port0Req,
    input  logic [lsuPkg::opWidth-1:0]      port0Op,
    input  logic [lsuPkg::addrWidth-1:0]    port0Addr,
    input  logic [lsuPkg::dataWidth-1:0]    port0Store,
    input  logic [lsuPkg::regAddrWidth-1:0] port0Dest,
    output logic                            port0Ack,
    output logic [lsuPkg::dataWidth-1:0]    port0Load,
    output logic [lsuPkg::regAddrWidth-1:0] port0LoadDest,
    output logic                            port0Fault,

    input  logic                            port1Req,
    input  logic [lsuPkg::opWidth-1:0]      port1Op,
    input  logic [lsuPkg::addrWidth-1:0]    port1Addr,
    input  logic [lsuPkg::dataWidth-1:0]    port1Store,
    input  logic [lsuPkg::regAddrWidth-1:0] port1Dest,
    output logic                            port1Ack,
    output logic [lsuPkg::dataWidth-1:0]    port1Load,
    output logic [lsuPkg::regAddrWidth-1:0] port1LoadDest,
    output logic                            port1Fault
);
    logic [lsuPkg::dataWidth-1:0]    loadData;
    logic [lsuPkg::regAddrWidth-1:0] loadDest;
    logic                            lsuFault;

    wbBus #(.tagWidth(lsuPkg::regAddrWidth)) armBus ();
    wbBus #(.tagWidth(lsuPkg::regAddrWidth)) fixedBus ();
    wbBus #(.tagWidth(lsuPkg::regAddrWidth)) ioBus ();
    wbBus #(.tagWidth(lsuPkg::regAddrWidth)) ramBus ();

    busArbiter i_busArbiter (
        .clk          (clk),
        .rstN         (rstN),
        .port0Req     (port0Req),
        .port0Op      (port0Op),
        .port0Addr    (port0Addr),
        .port0Store   (port0Store),
        .port0Dest    (port0Dest),
        .port0Ack     (port0Ack),
        .port1Req     (port1Req),
        .port1Op      (port1Op),
        .port1Addr    (port1Addr),
        .port1Store   (port1Store),
        .port1Dest    (port1Dest),
        .port1Ack     (port1Ack),
        .portLoad     (loadData),
        .portLoadDest (loadDest),
        .armBus       (armBus)
    );

    loadStoreUnit i_loadStoreUnit (
        .clk      (clk),
        .rstN     (rstN),
        .armBus   (armBus),
        .fault    (lsuFault),
        .fixedBus (fixedBus),
        .ioBus    (ioBus),
        .ramBus   (ramBus)
    );

    wordMemory #(.words(lsuPkg::fixedWords), .waitStates(0)) i_fixedMemory (
        .clk  (clk),
        .rstN (rstN),
        .bus  (fixedBus)
    );

    ioManager i_ioManager (
        .clk  (clk),
        .rstN (rstN),
        .bus  (ioBus)
    );

    wordMemory #(.words(lsuPkg::ramWords), .waitStates(2)) i_dataRam (
        .clk  (clk),
        .rstN (rstN),
        .bus  (ramBus)
    );

    // Load result is shared, fault follows the granted ack
    assign port0Load     = loadData;
    assign port1Load     = loadData;
    assign port0LoadDest = loadDest;
    assign port1LoadDest = loadDest;
    assign port0Fault    = lsuFault & port0Ack;
    assign port1Fault    = lsuFault & port1Ack;

endmodule

// ==== ioManager.sv ====
`timescale 1ns/100ps

module ioManager (
    input logic clk,
    input logic rstN,
    wbBus.slave bus
);
    logic [lsuPkg::dataWidth-1:0]      regs [lsuPkg::ioRegs];
    logic [$clog2(lsuPkg::ioRegs)-1:0] idx;
    logic                              access;
    logic                              ackQ;
    logic                              counterSel;
    logic [lsuPkg::dataWidth-1:0]      readData;

    assign idx        = bus.adr[$clog2(lsuPkg::ioRegs):1];  // Aliased over the IO range
    assign access     = bus.cyc & bus.stb & ~ackQ;
    assign counterSel = (int'(idx) == lsuPkg::ioRegs - 1);

    // Last register counts accepted writes and is read-only
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < lsuPkg::ioRegs; i++)
                regs[i] <= '0;
            ackQ <= 1'b0;
        end else begin
            ackQ <= access;
            if (access && bus.we) begin
                regs[lsuPkg::ioRegs-1] <= regs[lsuPkg::ioRegs-1] + 1'b1;
                if (!counterSel && bus.sel[0])
                    regs[idx][7:0] <= bus.datW[7:0];
                if (!counterSel && bus.sel[1])
                    regs[idx][15:8] <= bus.datW[15:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            readData <= regs[idx];
    end

    assign bus.ack  = ackQ;
    assign bus.datR = readData;

endmodule

// ==== wordMemory.sv ====
`timescale 1ns/100ps

module wordMemory #(
    parameter int words      = 512,
    parameter int waitStates = 0
) (
    input logic clk,
    input logic rstN,
    wbBus.slave bus
);
    logic [lsuPkg::dataWidth-1:0]    mem [words];
    logic [$clog2(words)-1:0]        idx;
    logic [$clog2(waitStates+2)-1:0] waitCnt;
    logic                            access;
    logic                            done;
    logic                            ackQ;
    logic [lsuPkg::dataWidth-1:0]    readData;

    // Word index, aliased modulo words
    assign idx = bus.adr[$clog2(words):1];

    assign access = bus.cyc & bus.stb & ~ackQ;
    assign done   = access & (int'(waitCnt) == waitStates);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waitCnt <= '0;
            ackQ    <= 1'b0;
        end else begin
            ackQ <= done;
            if (!access || done)
                waitCnt <= '0;
            else
                waitCnt <= waitCnt + 1'b1;  // Wait state
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            readData <= mem[idx];
            if (bus.we && bus.sel[0])
                mem[idx][7:0] <= bus.datW[7:0];
            if (bus.we && bus.sel[1])
                mem[idx][15:8] <= bus.datW[15:8];
        end
    end

    assign bus.ack  = ackQ;
    assign bus.datR = readData;

endmodule

// ==== loadStoreUnit.sv ====
`timescale 1ns/100ps

module loadStoreUnit (
    input  logic clk,
    input  logic rstN,
    wbBus.slave  armBus,
    output logic fault,
    wbBus.master fixedBus,
    wbBus.master ioBus,
    wbBus.master ramBus
);
    lsuPkg::regionSel             region;
    lsuPkg::lsuData               storeData;
    lsuPkg::lsuData               rawLoad;
    logic [1:0]                   size;
    logic                         badSize;
    logic [1:0]                   laneSel;
    logic                         slaveStb;
    logic [2:0]                   hit;
    logic                         slaveAck;
    logic                         faultAck;
    logic [7:0]                   loadByte;
    logic [lsuPkg::dataWidth-1:0] loadValue;

    assign size    = armBus.op[1:0];
    assign badSize = size[1];  // Double and quad not supported

    always_comb begin
        if (armBus.adr >= lsuPkg::ramBase)
            region = lsuPkg::ramRegion;
        else if (armBus.adr >= lsuPkg::ioLow && armBus.adr <= lsuPkg::ioHigh)
            region = lsuPkg::ioRegion;
        else
            region = lsuPkg::fixedRegion;
    end

    // Store byte lands in the lane picked by address bit 0
    always_comb begin
        storeData.word = armBus.datW;
        laneSel = 2'b11;
        if (size == lsuPkg::sizeByte) begin
            storeData.word = '0;
            if (armBus.adr[0]) begin
                storeData.bytes.hi = armBus.datW[7:0];
                laneSel = 2'b10;
            end else begin
                storeData.bytes.lo = armBus.datW[7:0];
                laneSel = 2'b01;
            end
        end
    end

    assign slaveStb = armBus.cyc & armBus.stb & ~badSize;
    assign hit[0]   = slaveStb & (region == lsuPkg::fixedRegion);
    assign hit[1]   = slaveStb & (region == lsuPkg::ioRegion);
    assign hit[2]   = slaveStb & (region == lsuPkg::ramRegion);

    assign fixedBus.cyc  = hit[0];
    assign fixedBus.stb  = hit[0];
    assign fixedBus.we   = armBus.we;
    assign fixedBus.sel  = laneSel & armBus.sel;
    assign fixedBus.adr  = armBus.adr;
    assign fixedBus.datW = storeData.word;
    assign fixedBus.tag  = armBus.tag;
    assign fixedBus.op   = armBus.op;

    assign ioBus.cyc  = hit[1];
    assign ioBus.stb  = hit[1];
    assign ioBus.we   = armBus.we;
    assign ioBus.sel  = laneSel & armBus.sel;
    assign ioBus.adr  = armBus.adr;
    assign ioBus.datW = storeData.word;
    assign ioBus.tag  = armBus.tag;
    assign ioBus.op   = armBus.op;

    assign ramBus.cyc  = hit[2];
    assign ramBus.stb  = hit[2];
    assign ramBus.we   = armBus.we;
    assign ramBus.sel  = laneSel & armBus.sel;
    assign ramBus.adr  = armBus.adr;
    assign ramBus.datW = storeData.word;
    assign ramBus.tag  = armBus.tag;
    assign ramBus.op   = armBus.op;

    always_comb begin
        case (region)
            lsuPkg::ioRegion: begin
                slaveAck     = ioBus.ack;
                rawLoad.word = ioBus.datR;
            end
            lsuPkg::ramRegion: begin
                slaveAck     = ramBus.ack;
                rawLoad.word = ramBus.datR;
            end
            default: begin
                slaveAck     = fixedBus.ack;
                rawLoad.word = fixedBus.datR;
            end
        endcase
    end

    // Load extension
    always_comb begin
        loadByte = armBus.adr[0] ? rawLoad.bytes.hi : rawLoad.bytes.lo;
        if (size == lsuPkg::sizeWord)
            loadValue = rawLoad.word;
        else if (armBus.op[lsuPkg::opSignedBit])
            loadValue = {{8{loadByte[7]}}, loadByte};
        else
            loadValue = {8'h00, loadByte};
    end

    // Fault acks one cycle after stb, once
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            faultAck <= 1'b0;
        else
            faultAck <= armBus.cyc & armBus.stb & badSize & ~faultAck;
    end

    assign fault       = faultAck;
    assign armBus.ack  = slaveAck | faultAck;
    assign armBus.datR = faultAck ? '0 : loadValue;

endmodule

// ==== busArbiter.sv ====
`timescale 1ns/100ps

module busArbiter (
    input  logic                            clk,
    input  logic                            rstN,

    input  logic                            port0Req,
    input  logic [lsuPkg::opWidth-1:0]      port0Op,
    input  logic [lsuPkg::addrWidth-1:0]    port0Addr,
    input  logic [lsuPkg::dataWidth-1:0]    port0Store,
    input  logic [lsuPkg::regAddrWidth-1:0] port0Dest,
    output logic                            port0Ack,

    input  logic                            port1Req,
    input  logic [lsuPkg::opWidth-1:0]      port1Op,
    input  logic [lsuPkg::addrWidth-1:0]    port1Addr,
    input  logic [lsuPkg::dataWidth-1:0]    port1Store,
    input  logic [lsuPkg::regAddrWidth-1:0] port1Dest,
    output logic                            port1Ack,

    output logic [lsuPkg::dataWidth-1:0]    portLoad,
    output logic [lsuPkg::regAddrWidth-1:0] portLoadDest,

    wbBus.master                            armBus
);
    logic                            busy;
    logic                            grant;      // Current port, or the one served last
    logic                            nextGrant;
    logic [lsuPkg::opWidth-1:0]      selOp;
    logic [lsuPkg::regAddrWidth-1:0] selDest;

    // On contention the port not served last goes first
    assign nextGrant = (port0Req && port1Req) ? ~grant : port1Req;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy  <= 1'b0;
            grant <= 1'b1;  // Port 0 wins the first tie
        end else if (busy) begin
            if (armBus.ack)
                busy <= 1'b0;
        end else if (port0Req || port1Req) begin
            busy  <= 1'b1;
            grant <= nextGrant;
        end
    end

    assign selOp   = grant ? port1Op : port0Op;
    assign selDest = grant ? port1Dest : port0Dest;

    assign armBus.cyc  = busy;
    assign armBus.stb  = busy;
    assign armBus.we   = selOp[lsuPkg::opStoreBit];
    assign armBus.sel  = 2'b11;  // Lanes narrowed in the LSU
    assign armBus.adr  = grant ? port1Addr : port0Addr;
    assign armBus.datW = grant ? port1Store : port0Store;
    assign armBus.tag  = selDest;
    assign armBus.op   = selOp;

    // Ack goes straight back, to the granted port only
    assign port0Ack = busy & armBus.ack & ~grant;
    assign port1Ack = busy & armBus.ack & grant;

    assign portLoad     = armBus.datR;
    assign portLoadDest = selDest;

endmodule

// ==== wbBus.sv ====
`timescale 1ns/100ps

interface wbBus #(
    parameter int tagWidth = lsuPkg::regAddrWidth
);
    logic                         cyc;
    logic                         stb;
    logic                         we;
    logic [1:0]                   sel;
    logic [lsuPkg::addrWidth-1:0] adr;
    logic [lsuPkg::dataWidth-1:0] datW;
    logic [lsuPkg::dataWidth-1:0] datR;
    logic                         ack;
    logic [tagWidth-1:0]          tag;   // Destination register of the access
    logic [lsuPkg::opWidth-1:0]   op;

    modport master (
        output cyc, stb, we, sel, adr, datW, tag, op,
        input  datR, ack
    );

    modport slave (
        input  cyc, stb, we, sel, adr, datW, tag, op,
        output datR, ack
    );

endinterface

// ==== lsuPkg.sv ====
package lsuPkg;

    localparam int dataWidth    = 16;
    localparam int addrWidth    = 16;
    localparam int regAddrWidth = 4;
    localparam int opWidth      = 4;

    // Minor opcode fields
    localparam int opStoreBit  = 3;
    localparam int opSignedBit = 2;
    localparam logic [1:0] sizeByte = 2'b00;
    localparam logic [1:0] sizeWord = 2'b01;

    // Region bounds, byte addresses
    localparam logic [addrWidth-1:0] ioLow   = 16'd384;
    localparam logic [addrWidth-1:0] ioHigh  = 16'd511;
    localparam logic [addrWidth-1:0] ramBase = 16'd1024;

    localparam int fixedWords = 512;
    localparam int ramWords   = 512;
    localparam int ioRegs     = 8;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } bytePair;

    // One bus word, or its two byte lanes
    typedef union packed {
        logic [dataWidth-1:0] word;
        bytePair              bytes;
    } lsuData;

    typedef enum logic [1:0] {
        fixedRegion,
        ioRegion,
        ramRegion
    } regionSel;

endpackage
